// File: source/gfxPkg.sv
package gfxPkg;

	//////////////////////////////////////////////////
	// widths and vector types
	//////////////////////////////////////////////////

	localparam int RowBits = 9;   // 512 rows
	localparam int ColBits = 10;  // 1024 columns, two per sram word

	typedef logic [15:0] wordT;        // cpu bus or sram data word
	typedef logic [15:0] coordT;       // coordinate reg as written by the cpu
	typedef logic [7:0] pixelT;        // palette index
	typedef logic [RowBits+ColBits-2:0] sramAddrT; // row + column pair
	typedef logic [5:0] paletteAddrT;  // 64 palette entries
	typedef logic [23:0] rgbT;         // RRGGBB
	typedef logic [6:0] regOffsetT;    // word offset inside the 256 byte window

	// register word offsets, byte address is offset*2
	localparam regOffsetT RegCommand = 7'd0;
	localparam regOffsetT RegX1 = 7'd1;
	localparam regOffsetT RegY1 = 7'd2;
	localparam regOffsetT RegX2 = 7'd3;
	localparam regOffsetT RegY2 = 7'd4;
	localparam regOffsetT RegColour = 7'd7; // also the pixel read-back slot

	// command codes
	localparam wordT CmdHLine = 16'h0001;
	localparam wordT CmdVLine = 16'h0002;
	localparam wordT CmdPutPixel = 16'h000A;
	localparam wordT CmdGetPixel = 16'h000B;
	localparam wordT CmdProgramPalette = 16'h0010;

	localparam coordT ResetX2 = 16'd1024;
	localparam coordT ResetY2 = 16'd512;
	localparam wordT ResetColour = 16'd4;  // blue

	typedef enum logic [3:0] {
		sIdle, sDecode, sPutPixel, sReadAddr, sReadWait, sReadCapture,
		sHLine, sVLine, sPalette
	} engStateT;

	//////////////////////////////////////////////////
	// structs crossing module boundaries
	//////////////////////////////////////////////////

	typedef struct packed {
		logic csN;
		logic asN;
		logic udsN;
		logic ldsN;
		logic rw;      // 1 = read
		wordT address;
		wordT data;
	} cpuBusT;

	typedef struct packed {
		coordT x1;
		coordT y1;
		coordT x2;
		coordT y2;
		wordT colour;
		wordT command;
	} drawRegsT;

	typedef struct packed {
		sramAddrT address;
		wordT data;
		logic udsN;
		logic ldsN;
		logic rw;      // 0 = write
	} sramCycleT;

	typedef struct packed {
		paletteAddrT addr;
		rgbT rgb;
		logic we;
	} paletteWriteT;

	// inactive values, strobes high and no palette write
	localparam sramCycleT SramIdle = '{address: '0, data: '0, udsN: 1'b1, ldsN: 1'b1, rw: 1'b1};
	localparam paletteWriteT PaletteIdle = '{addr: '0, rgb: '0, we: 1'b0};

endpackage

// File: source/cpuRegFile.sv
`timescale 1ns/1ps

module cpuRegFile import gfxPkg::*; (
	input logic Clk,
	input logic arstN,
	input cpuBusT bus,
	input logic idle,            // engine status
	input logic pixelLoad,       // one cycle capture pulse
	input pixelT pixelData,
	output drawRegsT regs,
	output logic commandPending,
	output wordT dataOutToCpu
);

	regOffsetT offset;
	logic inWindow;
	logic wrEn;
	logic rdEn;
	pixelT pixelLatch;  // pixel from last get pixel

	// merge cpu data into a register word, each lane on its own strobe
	function automatic wordT laneWrite(wordT old, wordT data, logic udsN, logic ldsN);
		wordT result;
		result = old;
		if (!udsN)
			result[15:8] = data[15:8];
		if (!ldsN)
			result[7:0] = data[7:0];
		return result;
	endfunction

	//////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////

	assign offset = bus.address[7:1];
	assign inWindow = (bus.address[15:8] == 8'h00);  // low 256 bytes only
	assign wrEn = !bus.csN && !bus.asN && !bus.rw && inWindow;
	assign rdEn = !bus.csN && !bus.asN && bus.rw && inWindow;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			regs <= '{x1: '0, y1: '0, x2: ResetX2, y2: ResetY2,
				colour: ResetColour, command: '0};
		end else if (wrEn) begin
			case (offset)
				RegCommand: regs.command <= laneWrite(regs.command, bus.data, bus.udsN, bus.ldsN);
				RegX1: regs.x1 <= laneWrite(regs.x1, bus.data, bus.udsN, bus.ldsN);
				RegY1: regs.y1 <= laneWrite(regs.y1, bus.data, bus.udsN, bus.ldsN);
				RegX2: regs.x2 <= laneWrite(regs.x2, bus.data, bus.udsN, bus.ldsN);
				RegY2: regs.y2 <= laneWrite(regs.y2, bus.data, bus.udsN, bus.ldsN);
				RegColour: regs.colour <= laneWrite(regs.colour, bus.data, bus.udsN, bus.ldsN);
				default: ;  // unmapped offsets ignored
			endcase
		end
	end

	// pending from the command write until the engine leaves idle
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN)
			commandPending <= 1'b0;
		else if (wrEn && offset == RegCommand)
			commandPending <= 1'b1;
		else if (!idle)
			commandPending <= 1'b0;  // engine low idle in sDecode
	end

	always_ff @(posedge Clk) begin
		if (pixelLoad)
			pixelLatch <= pixelData;
	end

	//////////////////////////////////////////////////
	// read back
	//////////////////////////////////////////////////

	always_comb begin
		dataOutToCpu = '0;  // nothing selected
		if (rdEn) begin
			if (offset == RegCommand)
				dataOutToCpu = {15'b0, idle};       // status word
			else if (offset == RegColour)
				dataOutToCpu = {8'b0, pixelLatch};  // offset hex E
		end
	end

endmodule

// File: source/drawEngine.sv
`timescale 1ns/1ps

module drawEngine import gfxPkg::*; (
	input logic Clk,
	input logic arstN,
	input logic asN,             // cpu address strobe
	input logic vsyncN,          // vertical sync from the vga side
	input wordT sramData,
	input drawRegsT regs,
	input logic commandPending,
	output logic idle,
	output logic pixelLoad,
	output pixelT pixelData,
	output sramCycleT sramCycle,
	output paletteWriteT paletteWrite
);

	engStateT state;
	engStateT nextState;
	logic [ColBits-1:0] cursorX;  // drawing cursor, regs stay untouched
	logic [RowBits-1:0] cursorY;
	logic lineEnd;

	//////////////////////////////////////////////////
	// state, idle flag and cursor
	//////////////////////////////////////////////////

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			state <= sIdle;
			idle <= 1'b1;
		end else begin
			state <= nextState;
			idle <= (nextState == sIdle);  // low from sDecode to command end
		end
	end

	always_ff @(posedge Clk) begin
		case (state)
			sDecode: begin
				cursorX <= regs.x1[ColBits-1:0];
				cursorY <= regs.y1[RowBits-1:0];
			end
			sHLine: cursorX <= cursorX + 1'b1;  // one pixel per cycle
			sVLine: cursorY <= cursorY + 1'b1;
			default: ;
		endcase
	end

	// end of line compares low bits only
	assign lineEnd = (state == sHLine) ? (cursorX == regs.x2[ColBits-1:0])
		: (cursorY == regs.y2[RowBits-1:0]);

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////

	always_comb begin
		nextState = sIdle;
		case (state)
			sIdle:
				if (commandPending && asN)  // wait for the cpu cycle to finish
					nextState = sDecode;
			sDecode:
				case (regs.command)
					CmdPutPixel: nextState = sPutPixel;
					CmdGetPixel: nextState = sReadAddr;
					CmdHLine: nextState = sHLine;
					CmdVLine: nextState = sVLine;
					CmdProgramPalette: nextState = sPalette;
					default: nextState = sIdle;  // unknown code dropped
				endcase
			sReadAddr: nextState = sReadWait;
			sReadWait: nextState = sReadCapture;   // sram answers here
			sHLine, sVLine:
				nextState = lineEnd ? sIdle : state;
			sPalette:
				nextState = vsyncN ? sPalette : sIdle;  // hold off until blanking
			default: nextState = sIdle;    // put pixel and capture are one state
		endcase
	end

	//////////////////////////////////////////////////
	// sram cycle, palette write, pixel capture
	//////////////////////////////////////////////////

	always_comb begin
		sramCycle = SramIdle;
		sramCycle.address = {cursorY, cursorX[ColBits-1:1]};  // two pixels per word
		sramCycle.data = {regs.colour[7:0], regs.colour[7:0]};
		case (state)
			sPutPixel, sHLine, sVLine: begin
				sramCycle.rw = 1'b0;
				sramCycle.udsN = cursorX[0];   // even x in upper byte
				sramCycle.ldsN = !cursorX[0];
			end
			sReadAddr: begin
				sramCycle.udsN = 1'b0;  // read both lanes
				sramCycle.ldsN = 1'b0;
			end
			default: ;
		endcase
	end

	always_comb begin
		paletteWrite = PaletteIdle;
		paletteWrite.addr = regs.colour[5:0];
		paletteWrite.rgb = {regs.x1[7:0], regs.y1};  // RR from x1, GGBB from y1
		paletteWrite.we = (state == sPalette) && !vsyncN;
	end

	assign pixelLoad = (state == sReadCapture);
	assign pixelData = cursorX[0] ? sramData[7:0] : sramData[15:8];

endmodule

// File: source/frameBufferPort.sv
`timescale 1ns/1ps

module frameBufferPort import gfxPkg::*; (
	input logic Clk,
	input logic arstN,
	input sramCycleT sramCycleIn,
	input paletteWriteT paletteIn,
	output sramCycleT sramCycleOut,
	output paletteWriteT paletteOut
);

	//////////////////////////////////////////////////
	// output register stage
	//////////////////////////////////////////////////

	// everything reaches the pins one cycle after the engine state
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN)
			sramCycleOut <= SramIdle;  // strobes high, read
		else
			sramCycleOut <= sramCycleIn;
	end

	// we already qualified with vsync low by the engine
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN)
			paletteOut <= PaletteIdle;
		else
			paletteOut <= paletteIn;
	end

endmodule

// File: source/graphicsController.sv
`timescale 1ns/1ps

module graphicsController import gfxPkg::*; (
	input logic Clk,
	input logic arstN,
	// cpu side
	input logic graphicsCsN,
	input logic asN,
	input logic udsN,
	input logic ldsN,
	input logic rw,
	input wordT addressIn,
	input wordT dataInFromCpu,
	output wordT dataOutToCpu,
	// vga and sram side
	input logic vsyncN,
	input wordT sramDataIn,
	output sramAddrT sramAddressOut,
	output wordT sramDataOut,
	output logic sramUdsOutN,
	output logic sramLdsOutN,
	output logic sramRwOut,
	output paletteAddrT colourPaletteAddr,
	output rgbT colourPaletteData,
	output logic colourPaletteWe
);

	cpuBusT cpuBus;
	drawRegsT regs;
	logic commandPending;
	logic idle;
	logic pixelLoad;
	pixelT pixelData;
	sramCycleT sramCycleNext;    // engine side, combinational
	sramCycleT sramCycleReg;     // pin side
	paletteWriteT paletteNext;
	paletteWriteT paletteReg;

	assign cpuBus = '{csN: graphicsCsN, asN: asN, udsN: udsN, ldsN: ldsN, rw: rw,
		address: addressIn, data: dataInFromCpu};

	cpuRegFile regFile_i (
		.Clk, .arstN, .bus(cpuBus), .idle, .pixelLoad, .pixelData,
		.regs, .commandPending, .dataOutToCpu
	);

	drawEngine engine_i (
		.Clk, .arstN, .asN(cpuBus.asN), .vsyncN, .sramData(sramDataIn),
		.regs, .commandPending, .idle, .pixelLoad, .pixelData,
		.sramCycle(sramCycleNext), .paletteWrite(paletteNext)
	);

	frameBufferPort port_i (
		.Clk, .arstN, .sramCycleIn(sramCycleNext), .paletteIn(paletteNext),
		.sramCycleOut(sramCycleReg), .paletteOut(paletteReg)
	);

	// unpack to pins
	assign sramAddressOut = sramCycleReg.address;
	assign sramDataOut = sramCycleReg.data;
	assign sramUdsOutN = sramCycleReg.udsN;
	assign sramLdsOutN = sramCycleReg.ldsN;
	assign sramRwOut = sramCycleReg.rw;
	assign colourPaletteAddr = paletteReg.addr;
	assign colourPaletteData = paletteReg.rgb;
	assign colourPaletteWe = paletteReg.we;

endmodule

// File: bench/scoreboard.sv
`timescale 1ns/1ps

module scoreboard import gfxPkg::*; (
	input logic Clk,
	input logic arstN,
	input logic csN,
	input logic asN,
	input logic udsN,
	input logic ldsN,
	input logic rw,
	input wordT address,
	input wordT data,
	input wordT dataOut,
	input sramAddrT sramAddress,
	input wordT sramData,
	input logic sramUdsN,
	input logic sramLdsN,
	input logic sramRw,
	input paletteAddrT paletteAddr,
	input rgbT paletteRgb,
	input logic paletteWe,
	output int errors,
	output int checks,
	output int pending
);

	coordT x1;
	coordT y1;
	coordT x2;
	coordT y2;
	wordT colour;
	wordT command;
	pixelT expPixel;
	int commands;
	wordT shadow [0:2**18-1];  // expected frame buffer
	sramCycleT writeQ[$];
	sramAddrT readQ[$];        // word address of each get pixel
	paletteWriteT paletteQ[$];

	initial begin
		errors = 0;
		checks = 0;
		pending = 0;
		commands = 0;
		x1 = '0;
		y1 = '0;
		x2 = ResetX2;
		y2 = ResetY2;
		colour = ResetColour;
		command = '0;
		expPixel = '0;
		for (int i = 0; i < 2**18; i++)
			shadow[i] = 16'(i) ^ {2'(i >> 16), 14'(i >> 4)};  // same fill as the sram model
	end

	task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual);
		end
	endtask

	function automatic wordT mergeLanes(wordT old, wordT value);
		return {udsN ? old[15:8] : value[15:8], ldsN ? old[7:0] : value[7:0]};
	endfunction

	// one pixel write, two pixels per word and even x in the upper byte
	function automatic sramCycleT pixelWrite(logic [9:0] x, logic [8:0] y);
		return '{address: {y, x[9:1]}, data: {colour[7:0], colour[7:0]},
			udsN: x[0], ldsN: !x[0], rw: 1'b0};
	endfunction

	//////////////////////////////////////////////////
	// expected traffic per command
	//////////////////////////////////////////////////

	task automatic queueCommand(wordT cmd);
		logic [9:0] x;
		logic [8:0] y;
		wordT w;
		paletteWriteT p;
		commands++;
		x = x1[9:0];
		y = y1[8:0];
		case (cmd)
			CmdPutPixel: writeQ.push_back(pixelWrite(x, y));
			CmdHLine:
				do begin
					writeQ.push_back(pixelWrite(x, y));
					x++;
				end while (x != x2[9:0] + 10'd1);
			CmdVLine:
				do begin
					writeQ.push_back(pixelWrite(x, y));
					y++;
				end while (y != y2[8:0] + 9'd1);
			CmdGetPixel: begin
				w = shadow[{y, x[9:1]}];
				expPixel = x[0] ? w[7:0] : w[15:8];
				readQ.push_back({y, x[9:1]});
			end
			CmdProgramPalette: begin
				p = '{addr: colour[5:0], rgb: {x1[7:0], y1}, we: 1'b1};
				paletteQ.push_back(p);
			end
			default: ;
		endcase
	endtask

	always @(posedge Clk) begin
		sramCycleT expW;
		sramAddrT expR;
		paletteWriteT expP;
		if (arstN) begin
			if (!csN && !asN && address[15:8] == 8'h00) begin
				if (!rw) begin
					case (address[7:1])
						RegX1: x1 = mergeLanes(x1, data);
						RegY1: y1 = mergeLanes(y1, data);
						RegX2: x2 = mergeLanes(x2, data);
						RegY2: y2 = mergeLanes(y2, data);
						RegColour: colour = mergeLanes(colour, data);
						RegCommand: begin
							command = mergeLanes(command, data);
							queueCommand(command);
						end
						default: ;
					endcase
				end else if (address[7:1] == RegColour)
					compare("dataOutToCpu", 32'({8'h00, expPixel}), 32'(dataOut));
				else if (address[7:1] == RegCommand && commands == 0)
					compare("dataOutToCpu", 32'h1, 32'(dataOut));  // idle after reset
			end
			if (!sramUdsN || !sramLdsN) begin
				if (!sramRw) begin
					if (writeQ.size() == 0) begin
						errors++;
						$display("unexpected SRAM write at address 0x%0h", sramAddress);
					end else begin
						expW = writeQ.pop_front();
						compare("sramAddressOut", 32'(expW.address), 32'(sramAddress));
						compare("sramDataOut", 32'(expW.data), 32'(sramData));
						compare("sramUdsOutN", 32'(expW.udsN), 32'(sramUdsN));
						compare("sramLdsOutN", 32'(expW.ldsN), 32'(sramLdsN));
					end
					if (!sramUdsN)
						shadow[sramAddress][15:8] = sramData[15:8];
					if (!sramLdsN)
						shadow[sramAddress][7:0] = sramData[7:0];
				end else if (readQ.size() == 0) begin
					errors++;
					$display("unexpected SRAM read at address 0x%0h", sramAddress);
				end else begin
					expR = readQ.pop_front();
					compare("sramAddressOut", 32'(expR), 32'(sramAddress));
					compare("sramUdsOutN", 32'h0, 32'(sramUdsN));  // read takes both lanes
					compare("sramLdsOutN", 32'h0, 32'(sramLdsN));
				end
			end
			if (paletteWe) begin
				if (paletteQ.size() == 0) begin
					errors++;
					$display("unexpected palette write to entry 0x%0h", paletteAddr);
				end else begin
					expP = paletteQ.pop_front();
					compare("colourPaletteAddr", 32'(expP.addr), 32'(paletteAddr));
					compare("colourPaletteData", 32'(expP.rgb), 32'(paletteRgb));
				end
			end
			pending = writeQ.size() + readQ.size() + paletteQ.size();
		end
	end

endmodule

// File: bench/graphicsController_assert.sv
`timescale 1ns/1ps

module graphicsControllerAssert (
	input logic Clk,
	input logic arstN,
	input logic vsyncN,
	input logic sramUdsOutN,
	input logic sramLdsOutN,
	input logic sramRwOut,
	input logic colourPaletteWe
);

	int failures = 0;  // failed assertion count

	// a pixel write touches one lane only
	singleLane: assert property (@(posedge Clk) disable iff (!arstN)
		!sramRwOut |-> (sramUdsOutN || sramLdsOutN))
		else begin
			failures++;
			$error("both byte strobes low during an SRAM write");
		end

	weOneCycle: assert property (@(posedge Clk) disable iff (!arstN)
		colourPaletteWe |=> !colourPaletteWe)
		else begin
			failures++;
			$error("palette write enable longer than one cycle");
		end

	// pin is one cycle behind the engine, so vsync is checked a cycle back
	weInBlanking: assert property (@(posedge Clk) disable iff (!arstN)
		colourPaletteWe |-> !$past(vsyncN))
		else begin
			failures++;
			$error("palette write enable without vsync low");
		end

endmodule

bind graphicsController graphicsControllerAssert assert_i (
	.Clk, .arstN, .vsyncN, .sramUdsOutN, .sramLdsOutN, .sramRwOut, .colourPaletteWe
);

// File: bench/graphicsControllerTb.sv
`timescale 1ns/1ps

module graphicsControllerTb import gfxPkg::*; ();

	localparam int NumCommands = 200;
	localparam int CycleLimit = NumCommands * (64 + 20) + 200;  // longest line plus bus overhead

	logic Clk;
	logic arstN;
	logic graphicsCsN;
	logic asN;
	logic udsN;
	logic ldsN;
	logic rw;
	wordT addressIn;
	wordT dataInFromCpu;
	wordT dataOutToCpu;
	logic vsyncN;
	wordT sramDataIn;
	sramAddrT sramAddressOut;
	wordT sramDataOut;
	logic sramUdsOutN;
	logic sramLdsOutN;
	logic sramRwOut;
	paletteAddrT colourPaletteAddr;
	rgbT colourPaletteData;
	logic colourPaletteWe;

	int seed;
	int vsyncSeed;
	int cycles;
	wordT sram [0:2**18-1];  // frame buffer, one word per column pair

	graphicsController dut_i (
		.Clk, .arstN, .graphicsCsN, .asN, .udsN, .ldsN, .rw, .addressIn, .dataInFromCpu,
		.dataOutToCpu, .vsyncN, .sramDataIn, .sramAddressOut, .sramDataOut, .sramUdsOutN,
		.sramLdsOutN, .sramRwOut, .colourPaletteAddr, .colourPaletteData, .colourPaletteWe
	);

	scoreboard sb_i (
		.Clk, .arstN, .csN(graphicsCsN), .asN, .udsN, .ldsN, .rw, .address(addressIn),
		.data(dataInFromCpu), .dataOut(dataOutToCpu), .sramAddress(sramAddressOut),
		.sramData(sramDataOut), .sramUdsN(sramUdsOutN), .sramLdsN(sramLdsOutN),
		.sramRw(sramRwOut), .paletteAddr(colourPaletteAddr), .paletteRgb(colourPaletteData),
		.paletteWe(colourPaletteWe), .errors(), .checks(), .pending()
	);

	// power-up contents, every address bit shows up in the word
	function automatic wordT fillWord(logic [17:0] a);
		return a[15:0] ^ {a[17:16], a[17:4]};
	endfunction

	initial begin
		Clk = 1'b0;
		forever #5 Clk = !Clk;
	end

	//////////////////////////////////////////////////
	// sram model and vsync
	//////////////////////////////////////////////////

	always @(posedge Clk) begin
		if (!sramRwOut) begin
			if (!sramUdsOutN)
				sram[sramAddressOut][15:8] <= sramDataOut[15:8];
			if (!sramLdsOutN)
				sram[sramAddressOut][7:0] <= sramDataOut[7:0];
		end else if (!sramUdsOutN || !sramLdsOutN)
			sramDataIn <= #1 sram[sramAddressOut];  // data one cycle after the address
	end

	always @(posedge Clk) begin
		logic [31:0] r;
		#1;
		r = $random(vsyncSeed);
		vsyncN = r[0];  // random blanking
	end

	always @(posedge Clk) begin
		cycles++;
		if (cycles > CycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", CycleLimit);
			$display("Regression failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// cpu bus tasks, each starts 1 ns after an edge
	//////////////////////////////////////////////////

	task automatic busWrite(regOffsetT off, wordT value, logic uN, logic lN);
		graphicsCsN = 1'b0;
		asN = 1'b0;
		rw = 1'b0;
		udsN = uN;
		ldsN = lN;
		addressIn = {8'h00, off, 1'b0};
		dataInFromCpu = value;
		@(posedge Clk);
		#1;
		graphicsCsN = 1'b1;
		asN = 1'b1;
		rw = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
	endtask

	task automatic busRead(regOffsetT off, output wordT value);
		graphicsCsN = 1'b0;
		asN = 1'b0;
		rw = 1'b1;
		udsN = 1'b0;
		ldsN = 1'b0;
		addressIn = {8'h00, off, 1'b0};
		@(posedge Clk);
		value = dataOutToCpu;
		#1;
		graphicsCsN = 1'b1;
		asN = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
	endtask

	// bus stays quiet two cycles so the engine can leave idle
	task automatic waitForIdle();
		wordT status;
		repeat (2) begin
			@(posedge Clk);
			#1;
		end
		status = '0;
		while (!status[0])
			busRead(RegCommand, status);
	endtask

	task automatic loadRegs(coordT x1, coordT y1, coordT x2, coordT y2, wordT colour);
		busWrite(RegX1, x1, 1'b0, 1'b0);
		busWrite(RegY1, y1, 1'b0, 1'b0);
		busWrite(RegX2, x2, 1'b0, 1'b0);
		busWrite(RegY2, y2, 1'b0, 1'b0);
		busWrite(RegColour, colour, 1'b0, 1'b0);
	endtask

	task automatic issue(wordT cmd);
		busWrite(RegCommand, cmd, 1'b0, 1'b0);
		waitForIdle();
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		coordT x;
		coordT y;
		coordT len;
		coordT lastX;
		coordT lastY;
		wordT colour;
		wordT rd;
		seed = 97;
		vsyncSeed = seed + 1;
		cycles = 0;
		arstN = 1'b0;
		graphicsCsN = 1'b1;
		asN = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
		rw = 1'b1;
		addressIn = '0;
		dataInFromCpu = '0;
		vsyncN = 1'b1;
		sramDataIn = '0;
		lastX = '0;
		lastY = '0;
		for (int i = 0; i < 2**18; i++)
			sram[i] = fillWord(18'(i));
		repeat (8) @(posedge Clk);
		#1;
		arstN = 1'b1;
		busRead(RegCommand, rd);  // status after reset
		for (int n = 0; n < NumCommands; n++) begin
			r = $random(seed);
			x = {6'b0, r[9:0]};
			y = {7'b0, r[18:10]};
			len = {10'b0, r[24:19]};  // up to 64 pixels
			r = $random(seed);
			colour = {8'b0, r[7:0]};
			case (r[10:8] % 3'd6)
				3'd0: begin
					loadRegs(x, y, x, y, colour);
					issue(CmdPutPixel);
					lastX = x;
					lastY = y;
				end
				3'd1: begin
					if (x + len > 16'd1023)
						x = 16'd1023 - len;
					loadRegs(x, y, x + len, y, colour);
					issue(CmdHLine);
				end
				3'd2: begin
					if (y + len > 16'd511)
						y = 16'd511 - len;
					loadRegs(x, y, x, y + len, colour);
					issue(CmdVLine);
				end
				3'd3: begin
					if (r[11]) begin  // revisit the last put pixel
						x = lastX;
						y = lastY;
					end
					loadRegs(x, y, x, y, colour);
					issue(CmdGetPixel);
					busRead(RegColour, rd);
				end
				3'd4: begin
					loadRegs(x, y, x, y, colour);
					issue(CmdProgramPalette);
				end
				default: begin
					loadRegs(x, y, x, y, colour);
					busWrite(RegX1, {r[23:16], r[31:24]}, 1'b1, 1'b0);  // low lane only
					issue(CmdPutPixel);
				end
			endcase
		end
		repeat (5) @(posedge Clk);
		$display("errors %0d, assertion failures %0d, checks %0d, outstanding %0d",
			sb_i.errors, dut_i.assert_i.failures, sb_i.checks, sb_i.pending);
		if (sb_i.errors == 0 && dut_i.assert_i.failures == 0 && sb_i.pending == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: filelist.f
source/gfxPkg.sv
source/cpuRegFile.sv
source/drawEngine.sv
source/frameBufferPort.sv
source/graphicsController.sv
bench/scoreboard.sv
bench/graphicsController_assert.sv
bench/graphicsControllerTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= graphicsControllerTb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert --timing

SOURCES := $(shell cat $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@! grep -q "Regression failed" $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
